/* rtl/cpu_cfg_pkg.sv */
// cpu configuration package with datapath widths, memory sizes and the program image
`default_nettype none

package cpu_cfg_pkg;

    localparam int word_w     = 16;
    localparam int reg_idx_w  = 4;
    localparam int num_regs   = 16;
    localparam int imem_aw    = 8;
    localparam int dmem_aw    = 6;
    localparam int imem_depth = 256;
    localparam int dmem_depth = 64;

    // program image, shared with the reference model in the testbench
    localparam prog_file = "prog.hex";

    typedef logic [word_w-1:0]    word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // pc counts words
    typedef logic [imem_aw-1:0]   imem_addr_t;
    typedef logic [dmem_aw-1:0]   dmem_addr_t;

endpackage

`default_nettype wire

/* rtl/isa_pkg.sv */
// instruction set package with opcodes, field positions and opcode classes
`default_nettype none

package isa_pkg;

    localparam int field_w = 4;

    typedef logic [field_w-1:0] opcode_t;

    localparam opcode_t op_nop  = 4'h0;
    localparam opcode_t op_add  = 4'h1;
    localparam opcode_t op_sub  = 4'h2;
    localparam opcode_t op_and  = 4'h3;
    localparam opcode_t op_or   = 4'h4;
    localparam opcode_t op_addi = 4'h5;
    localparam opcode_t op_li   = 4'h6;
    localparam opcode_t op_ld   = 4'h7;
    localparam opcode_t op_st   = 4'h8;
    localparam opcode_t op_in   = 4'h9;
    localparam opcode_t op_out  = 4'ha;
    localparam opcode_t op_bz   = 4'hb;

    // low bit of each 4-bit field
    localparam int op_lsb  = 0;
    localparam int rd_lsb  = 4;
    localparam int rs1_lsb = 8;
    localparam int rs2_lsb = 12;

    function automatic logic writes_rd(input opcode_t op);
        return op inside {op_add, op_sub, op_and, op_or, op_addi, op_li, op_ld, op_in};
    endfunction

    // value only known once the memory stage has run
    function automatic logic late_result(input opcode_t op);
        return op == op_ld || op == op_in;
    endfunction

endpackage

`default_nettype wire

/* rtl/pipe_if.sv */
// pipeline bundles between decode/execute and execute/memory
`default_nettype none

interface id_ex_if import cpu_cfg_pkg::*, isa_pkg::*; ();

    logic       valid;
    opcode_t    op;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    // register file values, before forwarding
    word_t      a;
    word_t      b;
    word_t      imm;
    imem_addr_t pc;

    modport producer (output valid, op, rd, rs1, rs2, a, b, imm, pc);
    modport consumer (input  valid, op, rd, rs1, rs2, a, b, imm, pc);

endinterface

interface ex_mem_if import cpu_cfg_pkg::*, isa_pkg::*; ();

    logic     valid;
    opcode_t  op;
    reg_idx_t rd;
    // alu value, memory address or output word
    word_t    result;
    word_t    store_data;

    modport producer (output valid, op, rd, result, store_data);
    modport consumer (input  valid, op, rd, result, store_data);

endinterface

`default_nettype wire

/* rtl/fetch_stage.sv */
// fetch stage with the program counter, instruction ROM and fetch/decode register
`default_nettype none

module fetch_stage import cpu_cfg_pkg::*; (
    input  wire             clock,
    input  wire             rst_n,
    input  wire             stall,
    input  wire             redirect,
    input  wire imem_addr_t target,
    output word_t           instr,
    output imem_addr_t      instr_pc,
    output logic            instr_valid
);

    word_t      rom [imem_depth];
    imem_addr_t pc;

    initial begin
        $readmemh(prog_file, rom);
    end

    // a taken branch wins over a load-use stall
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            instr_valid <= 1'b0;
        end else if (redirect) begin
            pc          <= target;
            instr_valid <= 1'b0;
        end else if (!stall) begin
            pc          <= pc + 1'b1;
            instr_valid <= 1'b1;
        end
    end

    // fetched word and its address, held while stalled
    always_ff @(posedge clock) begin
        if (!stall) begin
            instr    <= rom[pc];
            instr_pc <= pc;
        end
    end

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
// decode stage with register file, immediates, load-use stall and decode/execute register
`default_nettype none

module decode_stage import cpu_cfg_pkg::*, isa_pkg::*; (
    input  wire             clock,
    input  wire             rst_n,
    input  wire word_t      instr,
    input  wire imem_addr_t instr_pc,
    input  wire             instr_valid,
    input  wire             redirect,
    input  wire             wb_en,
    input  wire reg_idx_t   wb_rd,
    input  wire word_t      wb_data,
    output logic            stall,
    id_ex_if.producer       id_ex
);

    word_t    regs [num_regs];
    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    a_val;
    word_t    b_val;
    word_t    imm;

    assign op  = instr[op_lsb +: field_w];
    assign rd  = instr[rd_lsb +: field_w];
    assign rs1 = instr[rs1_lsb +: field_w];
    assign rs2 = instr[rs2_lsb +: field_w];

    // r0 is hardwired to zero, writeback in the same cycle passes straight through
    function automatic word_t read_reg(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        a_val = read_reg(rs1);
        b_val = read_reg(rs2);
    end

    always_comb begin
        case (op)
            op_addi: imm = {{(word_w-field_w){instr[rs2_lsb+field_w-1]}},
                            instr[rs2_lsb +: field_w]};
            op_li:   imm = {{(word_w-2*field_w){1'b0}}, instr[rs1_lsb +: 2*field_w]};
            // branch offset sits in the rd field
            op_bz:   imm = {{(word_w-field_w){instr[rd_lsb+field_w-1]}},
                            instr[rd_lsb +: field_w]};
            default: imm = '0;
        endcase
    end

    // ld or in right ahead of a reader of its rd
    assign stall = instr_valid && id_ex.valid && late_result(id_ex.op) && id_ex.rd != '0
                   && (id_ex.rd == rs1 || id_ex.rd == rs2);

    always_ff @(posedge clock) begin
        if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // bubble on stall, squash on redirect
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= instr_valid && !stall && !redirect;
        end
    end

    always_ff @(posedge clock) begin
        id_ex.op  <= instr_valid ? op : op_nop;
        id_ex.rd  <= rd;
        id_ex.rs1 <= rs1;
        id_ex.rs2 <= rs2;
        id_ex.a   <= a_val;
        id_ex.b   <= b_val;
        id_ex.imm <= imm;
        id_ex.pc  <= instr_pc;
    end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
// execute stage with operand forwarding, ALU, branch resolution and execute/memory register
`default_nettype none

module execute_stage import cpu_cfg_pkg::*, isa_pkg::*; (
    input  wire           clock,
    input  wire           rst_n,
    id_ex_if.consumer     id_ex,
    input  wire           wb_en,
    input  wire reg_idx_t wb_rd,
    input  wire word_t    wb_data,
    ex_mem_if.producer    ex_mem,
    output logic          redirect,
    output imem_addr_t    target
);

    logic  em_fwd_ok;
    logic  wb_fwd_ok;
    word_t a_fwd;
    word_t b_fwd;
    word_t result;

    // ld and in have no value yet in execute/memory
    assign em_fwd_ok = ex_mem.valid && writes_rd(ex_mem.op) && !late_result(ex_mem.op)
                       && ex_mem.rd != '0;
    assign wb_fwd_ok = wb_en && wb_rd != '0;

    // the younger producer wins
    function automatic word_t forward(input reg_idx_t idx, input word_t stored);
        if (em_fwd_ok && ex_mem.rd == idx) begin
            return ex_mem.result;
        end else if (wb_fwd_ok && wb_rd == idx) begin
            return wb_data;
        end
        return stored;
    endfunction

    always_comb begin
        a_fwd = forward(id_ex.rs1, id_ex.a);
        b_fwd = forward(id_ex.rs2, id_ex.b);
    end

    always_comb begin
        case (id_ex.op)
            op_add:  result = a_fwd + b_fwd;
            op_sub:  result = a_fwd - b_fwd;
            op_and:  result = a_fwd & b_fwd;
            op_or:   result = a_fwd | b_fwd;
            op_addi: result = a_fwd + id_ex.imm;
            op_li:   result = id_ex.imm;
            // address for ld/st, output word for out
            op_ld, op_st, op_out: result = a_fwd;
            default: result = '0;
        endcase
    end

    assign redirect = id_ex.valid && id_ex.op == op_bz && a_fwd == '0;
    assign target   = id_ex.pc + id_ex.imm[imem_aw-1:0];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid && !redirect;
        end
    end

    always_ff @(posedge clock) begin
        ex_mem.op         <= id_ex.op;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.result     <= result;
        ex_mem.store_data <= b_fwd;
    end

endmodule

`default_nettype wire

/* rtl/memory_stage.sv */
// memory stage with data RAM, input/output port and memory/writeback register
`default_nettype none

module memory_stage import cpu_cfg_pkg::*, isa_pkg::*; (
    input  wire        clock,
    input  wire        rst_n,
    ex_mem_if.consumer ex_mem,
    input  wire word_t read_in,
    output word_t      write_out,
    output logic       out_valid,
    output logic       wb_en,
    output reg_idx_t   wb_rd,
    output word_t      wb_data
);

    word_t      ram [dmem_depth];
    dmem_addr_t addr;
    word_t      mem_data;

    assign addr = ex_mem.result[dmem_aw-1:0];

    always_comb begin
        case (ex_mem.op)
            op_ld:   mem_data = ram[addr];
            op_in:   mem_data = read_in;
            default: mem_data = ex_mem.result;
        endcase
    end

    always_ff @(posedge clock) begin
        if (ex_mem.valid && ex_mem.op == op_st) begin
            ram[addr] <= ex_mem.store_data;
        end
    end

    // write_out keeps its value between out instructions
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_en     <= 1'b0;
            out_valid <= 1'b0;
            write_out <= '0;
        end else begin
            wb_en     <= ex_mem.valid && writes_rd(ex_mem.op);
            out_valid <= ex_mem.valid && ex_mem.op == op_out;
            if (ex_mem.valid && ex_mem.op == op_out) begin
                write_out <= ex_mem.result;
            end
        end
    end

    always_ff @(posedge clock) begin
        wb_rd   <= ex_mem.rd;
        wb_data <= mem_data;
    end

endmodule

`default_nettype wire

/* rtl/cpu_top.sv */
// cpu top level joining fetch, decode, execute and memory stages
`default_nettype none

module cpu_top import cpu_cfg_pkg::*; (
    input  wire        clock,
    input  wire        rst_n,
    input  wire word_t read_in,
    output word_t      write_out,
    output logic       out_valid
);

    word_t      instr;
    imem_addr_t instr_pc;
    logic       instr_valid;
    logic       stall;
    logic       redirect;
    imem_addr_t target;
    logic       wb_en;
    reg_idx_t   wb_rd;
    word_t      wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    fetch_stage i_fetch (
        .clock       (clock),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .target      (target),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid)
    );

    decode_stage i_decode (
        .clock       (clock),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .redirect    (redirect),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .stall       (stall),
        .id_ex       (id_ex.producer)
    );

    execute_stage i_execute (
        .clock    (clock),
        .rst_n    (rst_n),
        .id_ex    (id_ex.consumer),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .ex_mem   (ex_mem.producer),
        .redirect (redirect),
        .target   (target)
    );

    memory_stage i_memory (
        .clock     (clock),
        .rst_n     (rst_n),
        .ex_mem    (ex_mem.consumer),
        .read_in   (read_in),
        .write_out (write_out),
        .out_valid (out_valid),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

`default_nettype wire

/* tests/cpu_props.sv */
// pipeline control and output port checks bound into the cpu top level
`default_nettype none

module cpu_props import cpu_cfg_pkg::*; (
    input wire        clock,
    input wire        rst_n,
    input wire        stall,
    input wire        redirect,
    input wire word_t write_out,
    input wire        out_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    out_low_in_reset: assert property (@(posedge clock) !rst_n |-> !out_valid)
        else $error("out_valid high while reset is asserted");

    // write_out only moves together with an out_valid pulse
    out_held: assert property (@(posedge clock) disable iff (!rst_n)
        !out_valid |-> $stable(write_out))
        else $error("write_out changed without out_valid");

    control_known: assert property (@(posedge clock) disable iff (!rst_n)
        !$isunknown(redirect) && !$isunknown(stall))
        else $error("redirect or stall unknown after reset");

endmodule

bind cpu_top cpu_props i_props (
    .clock     (clock),
    .rst_n     (rst_n),
    .stall     (stall),
    .redirect  (redirect),
    .write_out (write_out),
    .out_valid (out_valid)
);

`default_nettype wire

/* tests/cpu_tb.sv */
// testbench for the pipelined cpu with an instruction-set reference model and output checker
`default_nettype none

module cpu_tb import cpu_cfg_pkg::*, isa_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 4;
    localparam int run_count    = 2;
    localparam int out_timeout  = 300;
    localparam int quiet_cycles = 40;
    localparam int model_steps  = 1000;

    logic  clock;
    logic  rst_n;
    word_t read_in;
    word_t write_out;
    logic  out_valid;

    word_t prog [imem_depth];
    word_t expected [$];
    int    seed;
    int    out_count;

    cpu_top i_dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .read_in   (read_in),
        .write_out (write_out),
        .out_valid (out_valid)
    );

    always #5 clock = ~clock;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // runs the program one instruction at a time and collects every out value
    function automatic int run_model(input word_t in_word);
        word_t      regs [num_regs];
        word_t      ram [dmem_depth];
        imem_addr_t pc;
        imem_addr_t next_pc;
        word_t      instr;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        int         i;
        int         step;

        for (i = 0; i < num_regs; i++) begin
            regs[i] = '0;
        end
        for (i = 0; i < dmem_depth; i++) begin
            ram[i] = '0;
        end
        expected.delete();
        pc = '0;
        for (step = 0; step < model_steps; step++) begin
            instr   = prog[pc];
            rd      = instr[7:4];
            a       = regs[instr[11:8]];
            b       = regs[instr[15:12]];
            next_pc = pc + 1'b1;
            case (instr[3:0])
                op_add:  regs[rd] = a + b;
                op_sub:  regs[rd] = a - b;
                op_and:  regs[rd] = a & b;
                op_or:   regs[rd] = a | b;
                op_addi: regs[rd] = a + {{12{instr[15]}}, instr[15:12]};
                op_li:   regs[rd] = {8'h00, instr[15:8]};
                op_ld:   regs[rd] = ram[a[dmem_aw-1:0]];
                op_st:   ram[a[dmem_aw-1:0]] = b;
                op_in:   regs[rd] = in_word;
                op_out:  expected.push_back(a);
                op_bz: begin
                    if (a == '0) begin
                        // taken branch onto itself ends the program
                        if (rd == '0) begin
                            return expected.size();
                        end
                        next_pc = pc + {{4{rd[3]}}, rd};
                    end
                end
                default: ;
            endcase
            // r0 reads zero whatever was written
            regs[0] = '0;
            pc      = next_pc;
        end
        return -1;
    endfunction

    task automatic apply_reset(input word_t value);
        int cycle;

        @(posedge clock);
        rst_n   <= 1'b0;
        read_in <= value;
        for (cycle = 0; cycle < reset_cycles; cycle++) begin
            @(posedge clock);
        end
        rst_n <= 1'b1;
    endtask

    task automatic wait_for_outputs(input int count);
        int cycle;

        cycle = 0;
        while (out_count < count && cycle < out_timeout) begin
            @(posedge clock);
            cycle++;
        end
        assert (out_count == count) else
            report_failure($sformatf("timeout after %0d cycles with %0d of %0d outputs seen",
                                     cycle, out_count, count));
    endtask

    // program spins in its self loop while the monitor catches any extra pulse
    task automatic check_quiet();
        int cycle;

        for (cycle = 0; cycle < quiet_cycles; cycle++) begin
            @(posedge clock);
        end
    endtask

    // outputs sampled away from the rising edge
    always @(negedge clock) begin
        if (!rst_n) begin
            out_count = 0;
            assert (!out_valid && write_out == '0) else
                report_failure("out_valid or write_out not cleared during reset");
        end else if (out_valid) begin
            assert (expected.size() != 0) else
                report_failure("out_valid pulse with no output left in the model");
            assert (write_out == expected[0]) else
                report_failure($sformatf("mismatch write_out expected %h actual %h",
                                         expected[0], write_out));
            void'(expected.pop_front());
            out_count++;
        end else if (out_count == 0) begin
            assert (write_out == '0) else
                report_failure($sformatf("mismatch write_out expected %h actual %h",
                                         16'h0000, write_out));
        end
    end

    initial begin
        word_t value;
        int    count;
        int    run;

        clock   = 1'b0;
        rst_n   = 1'b0;
        read_in = '0;
        seed    = 32'h5634a38f;
        $readmemh(prog_file, prog);
        for (run = 0; run < run_count; run++) begin
            value = word_t'($random(seed));
            count = run_model(value);
            assert (count > 0) else
                report_failure("reference model never reached the closing self loop");
            apply_reset(value);
            wait_for_outputs(count);
            check_quiet();
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* prog.hex */
// one instruction per line, hex digits from left: rs2 rs1 rd opcode
// li and addi take their immediate from the upper digits, bz its offset from rd
0019 // in   r1
0326 // li   r2, 03
2131 // add  r3, r1, r2
1344 // or   r4, r3, r1
040a // out  r4
2056 // li   r5, 20
3508 // st   [r5], r3
0567 // ld   r6, [r5]
e675 // addi r7, r6, -2
070a // out  r7
4783 // and  r8, r7, r4
080a // out  r8
1192 // sub  r9, r1, r1
093b // bz   r9, +3
010a // out  r1
020a // out  r2
022b // bz   r2, +2
060a // out  r6
000b // bz   r0, 0
0000 // nop
0000 // nop

/* cpu_pipe.f */
rtl/cpu_cfg_pkg.sv
rtl/isa_pkg.sv
rtl/pipe_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
tests/cpu_props.sv
tests/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the cpu_pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module cpu_tb -f cpu_pipe.f -o cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cpu_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TEST FAILED" "$log"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
